//--- design/decodePkg.sv
/* decode stage shared types */
package decodePkg;

   // 5-bit major opcodes, instr[15:11].
   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      SIIC  = 5'b00010,
      RTI   = 5'b00011,
      J     = 5'b00100,
      JR    = 5'b00101,
      JAL   = 5'b00110,
      JALR  = 5'b00111,
      ADDI  = 5'b01000,
      SUBI  = 5'b01001,
      XORI  = 5'b01010,
      ANDNI = 5'b01011,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      BLTZ  = 5'b01110,
      BGEZ  = 5'b01111,
      ST    = 5'b10000,
      LD    = 5'b10001,
      SLBI  = 5'b10010,
      STU   = 5'b10011,
      LBI   = 5'b11000,
      BTR   = 5'b11001,
      SEQ   = 5'b11100,
      SLT   = 5'b11101
   } opcode_e;

   typedef struct packed {
      logic [15:0] instr;
      logic [15:0] pc;
   } fetchPkt_t;

   typedef struct packed {
      logic        en;
      logic [2:0]  addr;
      logic [15:0] result;
      logic [15:0] imm;
      logic [15:0] pc;
      logic        lbi;  // write imm.
      logic        link; // write pc+2, wins over lbi.
   } wbPkt_t;

   typedef struct packed {
      logic [1:0] brKind;  // instr[12:11].
      logic       isBranch;
      logic       isJump;
      logic       halt;
      logic       lbi;
      logic       link;
      logic [2:0] dstAddr;
   } ctrl_t;

   typedef struct packed {
      logic [15:0] rs1Data;
      logic [15:0] rs2Data;
      logic [15:0] imm;
      logic [15:0] pc;
      logic        pcSel;
      ctrl_t       ctrl;
   } decPkt_t;

   typedef struct packed {
      logic [2:0] rs;
      logic [2:0] rt;
   } srcRegs_t;

   function automatic opcode_e opcodeOf(input logic [15:0] instr);
      return opcode_e'(instr[15:11]);
   endfunction

   // jal/jalr family reads r7 as rs.
   function automatic srcRegs_t srcRegs(input logic [15:0] instr);
      srcRegs_t s;
      s.rs = (instr[15:12] == 4'b0011) ? 3'd7 : instr[10:8];
      s.rt = instr[7:5];
      return s;
   endfunction

   // rd position depends on the format.
   function automatic logic [2:0] rdField(input logic [15:0] instr);
      logic [2:0] rd;
      casez (instr[15:11])
         5'b11001, 5'b1101?, 5'b111??: rd = instr[4:2];  // r-format.
         5'b11000, 5'b10010, 5'b10011: rd = instr[10:8]; // lbi, slbi, stu.
         default: rd = instr[7:5];                       // i-format 1.
      endcase
      return rd;
   endfunction

endpackage

//--- design/creditQueue.sv
/* fetch input queue with credit return */
`timescale 1ns/1ns

module creditQueue
   import decodePkg::*;
#(
   parameter int QDEPTH = 4
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      inValid,
   input  fetchPkt_t inPkt,
   input  logic      deq,
   output fetchPkt_t head,
   output logic      headValid,
   output logic      credit
);

   localparam int PW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
   localparam int CW = $clog2(QDEPTH + 1);

   fetchPkt_t     mem [QDEPTH]; // payload store.
   logic [PW-1:0] wrPtr;
   logic [PW-1:0] rdPtr;
   logic [CW-1:0] count;        // occupied entries.
   logic          push;
   logic          pop;

   // wrap at QDEPTH, works for any depth.
   function automatic logic [PW-1:0] nextPtr(input logic [PW-1:0] p);
      return (p == PW'(QDEPTH - 1)) ? '0 : p + PW'(1);
   endfunction

   assign headValid = (count != '0);
   assign head      = mem[rdPtr];      // head shows as soon as written.
   assign pop       = deq & headValid;
   assign push      = inValid & (count != CW'(QDEPTH)); // fetch holds a credit.

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wrPtr] <= inPkt;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wrPtr  <= '0;
         rdPtr  <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (pop) begin
            rdPtr <= nextPtr(rdPtr);
         end
         // simultaneous push and pop leaves count alone.
         case ({push, pop})
            2'b10:   count <= count + CW'(1);
            2'b01:   count <= count - CW'(1);
            default: count <= count;
         endcase
         credit <= pop; // one credit per dequeued entry.
      end
   end

endmodule

//--- design/regFile.sv
/* register file with writeback select */
`timescale 1ns/1ns

module regFile
   import decodePkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] instr,
   input  wbPkt_t      wbPkt,
   output logic [15:0] rs1Data,
   output logic [15:0] rs2Data
);

   logic [15:0] regs [8];
   srcRegs_t    src;     // read addresses.
   logic [15:0] wrData;
   logic        hitRs;
   logic        hitRt;

   assign src = srcRegs(instr);

   // link beats lbi, result otherwise.
   always_comb begin
      if (wbPkt.link) begin
         wrData = wbPkt.pc + 16'd2; // return address.
      end else if (wbPkt.lbi) begin
         wrData = wbPkt.imm;
      end else begin
         wrData = wbPkt.result;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wbPkt.en) begin
         regs[wbPkt.addr] <= wrData;
      end
   end

   // same-cycle write goes straight to the read port.
   assign hitRs = wbPkt.en && (wbPkt.addr == src.rs);
   assign hitRt = wbPkt.en && (wbPkt.addr == src.rt);

   assign rs1Data = hitRs ? wrData : regs[src.rs];
   assign rs2Data = hitRt ? wrData : regs[src.rt];

endmodule

//--- design/ctrlDecode.sv
/* opcode control decoder */
`timescale 1ns/1ns

module ctrlDecode
   import decodePkg::*;
(
   input  logic [15:0] instr,
   output ctrl_t       ctrl,
   output logic [15:0] imm
);

   opcode_e op;
   logic    opBranch;  // 011xx.
   logic    opJump;    // 001xx.
   logic    opLink;
   logic    opLbi;
   logic    longImm;   // j and jal.
   logic    midImm;    // branches and lbi.

   assign op = opcodeOf(instr);

   always_comb begin
      opBranch = 1'b0;
      opJump   = 1'b0;
      opLink   = 1'b0;
      case (op)
         BEQZ, BNEZ, BLTZ, BGEZ: opBranch = 1'b1;
         J, JR:                  opJump = 1'b1;
         JAL, JALR: begin
            opJump = 1'b1;
            opLink = 1'b1; // writes return address.
         end
         default: begin
            opBranch = 1'b0;
         end
      endcase
   end

   assign opLbi   = (op == LBI);
   assign longImm = (op == J) || (op == JAL);
   assign midImm  = opBranch || opLbi;

   always_comb begin
      ctrl.brKind   = instr[12:11];  // condition kind, only meaningful on branches.
      ctrl.isBranch = opBranch;
      ctrl.isJump   = opJump;
      ctrl.halt     = (op == HALT);
      ctrl.lbi      = opLbi;
      ctrl.link     = opLink;
      // link target is always r7.
      ctrl.dstAddr  = opLink ? 3'd7 : rdField(instr);
   end

   // sign extension by immediate width.
   always_comb begin
      if (longImm) begin
         imm = {{5{instr[10]}}, instr[10:0]};  // 11-bit displacement.
      end else if (midImm) begin
         imm = {{8{instr[7]}}, instr[7:0]};    // 8-bit.
      end else begin
         imm = {{11{instr[4]}}, instr[4:0]};   // 5-bit i-type.
      end
   end

endmodule

//--- design/issueUnit.sv
/* branch resolve and packet issue */
`timescale 1ns/1ns

module issueUnit
   import decodePkg::*;
#(
   parameter int OUTCREDITS = 2
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        headValid,
   input  fetchPkt_t   head,
   input  ctrl_t       ctrl,
   input  logic [15:0] imm,
   input  logic [15:0] rs1Data,
   input  logic [15:0] rs2Data,
   input  logic        decCredit,
   output logic        deq,
   output logic        decValid,
   output decPkt_t     decPkt
);

   localparam int CW = $clog2(OUTCREDITS + 1);

   logic [CW-1:0] credits;  // free downstream slots.
   logic          zFlag;
   logic          sFlag;
   logic          taken;
   logic          pcSel;
   logic          canIssue;

   assign zFlag = (rs1Data == 16'h0000);
   assign sFlag = rs1Data[15];

   always_comb begin
      case (ctrl.brKind)
         2'b00:   taken = zFlag;   // beqz.
         2'b01:   taken = ~zFlag;  // bnez.
         2'b10:   taken = sFlag;   // bltz.
         default: taken = ~sFlag;  // bgez.
      endcase
   end

   // halt never redirects.
   assign pcSel    = ((ctrl.isBranch & taken) | ctrl.isJump) & ~ctrl.halt;
   assign canIssue = headValid & (credits != '0);
   assign deq      = canIssue;

   always_ff @(posedge clk) begin
      if (canIssue) begin
         decPkt.rs1Data <= rs1Data;
         decPkt.rs2Data <= rs2Data;
         decPkt.imm     <= imm;
         decPkt.pc      <= head.pc;
         decPkt.pcSel   <= pcSel;
         decPkt.ctrl    <= ctrl;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decValid <= 1'b0;
         credits  <= CW'(OUTCREDITS);
      end else begin
         decValid <= canIssue; // one cycle per packet.
         case ({decCredit, canIssue})
            2'b10:   credits <= credits + CW'(1);
            2'b01:   credits <= credits - CW'(1);
            default: credits <= credits;  // return and send cancel.
         endcase
      end
   end

endmodule

//--- design/decodeStage.sv
/* decode stage top */
`timescale 1ns/1ns

module decodeStage
   import decodePkg::*;
#(
   parameter int QDEPTH     = 4,
   parameter int OUTCREDITS = 2
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      fetchValid,
   input  fetchPkt_t fetchPkt,
   output logic      fetchCredit,
   input  wbPkt_t    wbPkt,
   output logic      decValid,
   output decPkt_t   decPkt,
   input  logic      decCredit
);

   fetchPkt_t   head;       // queue head.
   logic        headValid;
   logic        deq;
   ctrl_t       ctrl;
   logic [15:0] imm;
   logic [15:0] rs1Data;
   logic [15:0] rs2Data;

   creditQueue #(.QDEPTH(QDEPTH)) queueInst (
      .clk       (clk),
      .rst       (rst),
      .inValid   (fetchValid),
      .inPkt     (fetchPkt),
      .deq       (deq),
      .head      (head),
      .headValid (headValid),
      .credit    (fetchCredit)
   );

   // register read and decode both work off the head.
   regFile regFileInst (
      .clk     (clk),
      .rst     (rst),
      .instr   (head.instr),
      .wbPkt   (wbPkt),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data)
   );

   ctrlDecode ctrlInst (
      .instr (head.instr),
      .ctrl  (ctrl),
      .imm   (imm)
   );

   issueUnit #(.OUTCREDITS(OUTCREDITS)) issueInst (
      .clk       (clk),
      .rst       (rst),
      .headValid (headValid),
      .head      (head),
      .ctrl      (ctrl),
      .imm       (imm),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .decCredit (decCredit),
      .deq       (deq),
      .decValid  (decValid),
      .decPkt    (decPkt)
   );

endmodule

//--- test/decodeStage_assert.sv
/* decode stage bound checks */
`timescale 1ns/1ns

module decodeStageAssert #(
   parameter int OUTCREDITS = 2
) (
   input logic                             clk,
   input logic                             rst,
   input logic                             fetchValid,
   input logic                             fetchCredit,
   input logic                             decValid,
   input logic [$clog2(OUTCREDITS+1)-1:0]  credits
);

   int accepted;   // packets taken from fetch.
   int returned;   // credits handed back to fetch.

   always_ff @(posedge clk) begin
      if (rst) begin
         accepted <= 0;
         returned <= 0;
      end else begin
         if (fetchValid) accepted <= accepted + 1;
         if (fetchCredit) returned <= returned + 1;
      end
   end

   creditBound: assert property (@(posedge clk) disable iff (rst)
      int'(credits) <= OUTCREDITS) else $error("downstream credit counter above its limit");

   // the issuing edge saw a free slot.
   sendWithCredit: assert property (@(posedge clk) disable iff (rst)
      decValid |-> $past(credits) != '0) else $error("packet sent with no downstream credit");

   creditNotAhead: assert property (@(posedge clk) disable iff (rst)
      fetchCredit |-> returned < accepted) else $error("fetch credit with no packet taken");

   quietAfterReset: assert property (@(posedge clk)
      rst |=> !decValid && !fetchCredit) else $error("outputs active right after reset");

endmodule

bind decodeStage decodeStageAssert #(
   .OUTCREDITS (OUTCREDITS)
) assertInst (
   .clk         (clk),
   .rst         (rst),
   .fetchValid  (fetchValid),
   .fetchCredit (fetchCredit),
   .decValid    (decValid),
   .credits     (issueInst.credits)
);

//--- test/decodeStage_tb.sv
/* decode stage testbench */
`timescale 1ns/1ns

module decodeStage_tb
   import decodePkg::*;
();

   localparam int QDEPTH     = 4;
   localparam int OUTCREDITS = 2;
   localparam opcode_e OPS [14] = '{HALT, J, JR, JAL, JALR, BEQZ, BNEZ, BLTZ, BGEZ,
                                     LBI, ADDI, SUBI, SEQ, ST};

   logic        clk;
   logic        rst;
   logic        fetchValid;
   fetchPkt_t   fetchPkt;
   logic        fetchCredit;
   wbPkt_t      wbPkt;
   logic        decValid;
   decPkt_t     decPkt;
   logic        decCredit;

   logic [15:0] shadow [8];   // reference register file.
   decPkt_t     expQ [$];     // expected packets, oldest first.
   int          fetchCreds;   // credits fetch holds.
   int          owed;         // downstream slots in use.
   int          holdPct;      // chance in percent of withholding decCredit.
   integer      seed = 32'h1414;
   string       testName;
   logic [15:0] pcNext;

   decodeStage #(.QDEPTH(QDEPTH), .OUTCREDITS(OUTCREDITS)) dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   // decoded packet as the decode rules give it.
   function automatic decPkt_t expectedPkt(input logic [15:0] instr, input logic [15:0] pc);
      decPkt_t  p;
      srcRegs_t s;
      opcode_e  op;
      logic     taken;
      logic [2:0] rd;
      s = srcRegs(instr);
      op = opcode_e'(instr[15:11]);
      p.rs1Data = shadow[s.rs];
      p.rs2Data = shadow[s.rt];
      p.pc = pc;
      p.ctrl.brKind = instr[12:11];
      p.ctrl.isBranch = (instr[15:13] == 3'b011);
      p.ctrl.isJump = (instr[15:13] == 3'b001);
      p.ctrl.halt = (op == HALT);
      p.ctrl.lbi = (op == LBI);
      p.ctrl.link = (op == JAL) || (op == JALR);
      case (op)
         LBI:     rd = instr[10:8];
         SEQ:     rd = instr[4:2];   // r-format.
         default: rd = instr[7:5];
      endcase
      p.ctrl.dstAddr = p.ctrl.link ? 3'd7 : rd;
      if (op == J || op == JAL) p.imm = {{5{instr[10]}}, instr[10:0]};
      else if (p.ctrl.isBranch || p.ctrl.lbi) p.imm = {{8{instr[7]}}, instr[7:0]};
      else p.imm = {{11{instr[4]}}, instr[4:0]};
      case (op)
         BEQZ:    taken = (p.rs1Data == 16'h0);
         BNEZ:    taken = (p.rs1Data != 16'h0);
         BLTZ:    taken = p.rs1Data[15];
         BGEZ:    taken = ~p.rs1Data[15];
         default: taken = 1'b0;
      endcase
      p.pcSel = (taken | p.ctrl.isJump) & ~p.ctrl.halt;   // halt never redirects.
      return p;
   endfunction

   // outputs are sampled half a cycle after the edge.
   task automatic collect();
      decPkt_t want;
      if (fetchCredit) begin
         fetchCreds++;
         if (fetchCreds > QDEPTH) abortRun("fetch holds more credits than the queue depth");
      end
      if (decValid) begin
         if (expQ.size() == 0) abortRun("decValid seen with no packet outstanding");
         want = expQ.pop_front();
         if (decPkt !== want) begin
            $display("MISMATCH %s expected %h actual %h", testName, want, decPkt);
            abortRun("decoded packet differs from the model");
         end
         owed++;
         if (owed > OUTCREDITS) abortRun("downstream buffer overrun");
      end
   endtask

   task automatic tick();
      @(negedge clk);
      fetchValid = 1'b0;
      wbPkt      = '0;
      decCredit  = 1'b0;
      collect();
      if (owed > 0 && int'($unsigned($random(seed)) % 100) >= holdPct) begin
         decCredit = 1'b1;   // free one slot.
         owed--;
      end
   endtask

   task automatic sendPkt(input logic [15:0] instr);
      int waitCnt = 0;
      tick();
      while (fetchCreds == 0) begin
         tick();
         waitCnt++;
         if (waitCnt > 200) abortRun("timeout waiting for a fetch credit");
      end
      fetchValid     = 1'b1;
      fetchPkt.instr = instr;
      fetchPkt.pc    = pcNext;
      fetchCreds--;
      pcNext += 16'd2;   // unique pc per packet.
   endtask

   task automatic issueInstr(input logic [15:0] instr);
      sendPkt(instr);
      expQ.push_back(expectedPkt(instr, fetchPkt.pc));
   endtask

   task automatic drain();
      int waitCnt = 0;
      while (expQ.size() != 0 || owed != 0) begin
         tick();
         waitCnt++;
         if (waitCnt > 500) abortRun("timeout waiting for decoded packets");
      end
   endtask

   // link wins over lbi, result otherwise.
   task automatic driveWrite(input wbPkt_t w);
      wbPkt = w;
      if (w.en) shadow[w.addr] = w.link ? w.pc + 16'd2 : (w.lbi ? w.imm : w.result);
   endtask

   task automatic writeReg(input wbPkt_t w);
      drain();   // nothing in flight reads stale data.
      tick();
      driveWrite(w);
   endtask

   function automatic wbPkt_t plainWrite(input logic [2:0] addr, input logic [15:0] value);
      wbPkt_t w = '0;
      w.en     = 1'b1;
      w.addr   = addr;
      w.result = value;
      return w;
   endfunction

   task automatic randWb(input logic [2:0] addr, output wbPkt_t w);
      w.en     = 1'b1;
      w.addr   = addr;
      w.result = 16'($random(seed));
      w.imm    = 16'($random(seed));
      w.pc     = 16'($random(seed));
      w.lbi    = 1'($random(seed));
      w.link   = 1'($random(seed));
   endtask

   task automatic randInstr(output logic [15:0] instr);
      logic [3:0] idx = 4'($unsigned($random(seed)) % 14);
      instr = {OPS[idx], 11'($random(seed))};
   endtask

   // write lands in the cycle the packet sits at the head.
   task automatic bypassCase(input logic [15:0] instr, input logic [2:0] addr);
      wbPkt_t w;
      drain();
      sendPkt(instr);
      tick();
      randWb(addr, w);
      driveWrite(w);
      expQ.push_back(expectedPkt(instr, fetchPkt.pc));
   endtask

   // reset hits the edge that would issue the head packet.
   task automatic resetMidStream(input logic [15:0] instr);
      drain();
      sendPkt(instr);
      tick();
      rst = 1'b1;
      repeat (3) @(negedge clk);
      rst        = 1'b0;
      fetchCreds = QDEPTH;   // queued packet is dropped.
      owed       = 0;
      shadow     = '{default: '0};
   endtask

   initial begin
      wbPkt_t      w;
      logic [15:0] instr;
      rst        = 1'b1;
      fetchValid = 1'b0;
      fetchPkt   = '0;
      wbPkt      = '0;
      decCredit  = 1'b0;
      fetchCreds = QDEPTH;
      owed       = 0;
      holdPct    = 0;
      pcNext     = 16'h0100;
      shadow     = '{default: '0};
      repeat (3) @(negedge clk);
      rst = 1'b0;

      testName = "wbSelect";
      for (int r = 0; r < 8; r++) issueInstr({ADDI, 3'(r), 3'(7 - r), 5'h0});   // all zero.
      for (int i = 0; i < 16; i++) begin
         randWb(3'($random(seed)), w);
         writeReg(w);
      end
      for (int r = 0; r < 8; r++) issueInstr({ADDI, 3'(r), 3'(r + 1), 5'h1});

      testName = "srcRead";
      for (int i = 0; i < 20; i++) begin
         randInstr(instr);
         issueInstr(instr);
      end
      bypassCase({ADDI, 3'd2, 3'd5, 5'h3}, 3'd2);   // rs port.
      bypassCase({ADDI, 3'd2, 3'd5, 5'h3}, 3'd5);   // rt port.
      bypassCase({JALR, 3'd1, 3'd4, 5'h0}, 3'd7);   // r7 as rs.

      testName = "branch";
      writeReg(plainWrite(3'd0, 16'h0000));
      writeReg(plainWrite(3'd1, 16'h0001));
      writeReg(plainWrite(3'd2, 16'h7fff));
      writeReg(plainWrite(3'd3, 16'h8000));
      writeReg(plainWrite(3'd4, 16'hffff));
      writeReg(plainWrite(3'd5, 16'h1234));
      for (int b = 0; b < 4; b++) begin
         for (int r = 0; r < 6; r++) issueInstr({3'b011, 2'(b), 3'(r), 8'($random(seed))});
      end
      for (int j = 0; j < 8; j++) issueInstr({3'b001, 2'(j % 4), 11'($random(seed))});
      issueInstr({HALT, 11'($random(seed))});

      testName = "immCtrl";
      for (int i = 0; i < 40; i++) begin
         if (i % 8 == 0) begin
            randWb(3'($random(seed)), w);
            writeReg(w);
         end
         randInstr(instr);
         issueInstr(instr);
      end

      testName = "flow";
      holdPct = 70;   // heavy back-pressure.
      for (int i = 0; i < 60; i++) begin
         randInstr(instr);
         issueInstr(instr);
      end
      holdPct = 0;
      drain();
      holdPct = 100;   // downstream full, queue fills behind it.
      for (int i = 0; i < QDEPTH + OUTCREDITS; i++) begin
         randInstr(instr);
         issueInstr(instr);
      end
      repeat (10) tick();
      if (fetchCreds != 0) abortRun("fetch credit returned while downstream was full");
      holdPct = 0;
      drain();

      testName = "reset";
      resetMidStream({ADDI, 3'd1, 3'd2, 5'h4});
      for (int r = 0; r < 8; r++) issueInstr({ADDI, 3'(r), 3'(7 - r), 5'h0});   // zero again.
      drain();

      $display("TEST PASS");
      $finish;
   end

endmodule

//--- tb.f
design/decodePkg.sv
design/creditQueue.sv
design/regFile.sv
design/ctrlDecode.sv
design/issueUnit.sv
design/decodeStage.sv
test/decodeStage_assert.sv
test/decodeStage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module decodeStage_tb -f tb.f
./obj_dir/VdecodeStage_tb
